//--- source/mem_pkg.sv
package mem_pkg;

    // bus and line geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int OFFSET_W       = $clog2(LINE_W / 8);

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // client word
    typedef logic [WORD_W-1:0] word_t;

    // one memory beat, little-endian bytes
    typedef logic [BEAT_W-1:0] beat_t;

    // word k sits at bits 32k and up
    typedef logic [LINE_W-1:0] line_t;

    // line address without the offset
    typedef logic [ADDR_W-OFFSET_W-1:0] line_tag_t;

    typedef logic [WORD_W/8-1:0] byte_mask_t;

endpackage : mem_pkg

//--- source/line_port_if.sv
`timescale 1ns/100ps

// line request and response between buffer, arbiter and adapter
interface line_port_if
    import mem_pkg::*;
();

    logic  req;
    logic  we;
    addr_t addr;
    line_t wline;
    line_t rline;
    logic  resp;

    modport client (
        output req, we, addr, wline,
        input  rline, resp
    );

    modport server (
        input  req, we, addr, wline,
        output rline, resp
    );

endinterface : line_port_if

//--- source/fetch_line_buffer.sv
`timescale 1ns/100ps

module fetch_line_buffer
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_req_i,
    input  addr_t       fetch_addr_i,
    output logic        fetch_valid_o,
    output word_t       fetch_inst_o,
    line_port_if.client mem
);

    logic      line_valid;
    line_tag_t line_tag;
    line_t     line_q;
    logic      pending;
    addr_t     addr_q;
    logic      hit;

    assign hit = line_valid && (fetch_addr_i[ADDR_W-1:OFFSET_W] == line_tag);

    // read-only side, refill request held until resp
    assign mem.req   = pending;
    assign mem.we    = 1'b0;
    assign mem.addr  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem.wline = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid    <= 1'b0;
            pending       <= 1'b0;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            if (pending && mem.resp) begin
                line_valid    <= 1'b1;
                pending       <= 1'b0;
                fetch_valid_o <= 1'b1;
            end else if (fetch_req_i && !hit) begin
                pending <= 1'b1;
            end else if (fetch_req_i) begin
                fetch_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req_i) begin
            addr_q <= fetch_addr_i;
        end
        if (pending && mem.resp) begin
            line_q       <= mem.rline;
            line_tag     <= addr_q[ADDR_W-1:OFFSET_W];
            // word comes straight from the refill line
            fetch_inst_o <= mem.rline[WORD_W*addr_q[OFFSET_W-1:2] +: WORD_W];
        end else if (fetch_req_i && hit) begin
            fetch_inst_o <= line_q[WORD_W*fetch_addr_i[OFFSET_W-1:2] +: WORD_W];
        end
    end

    // client waits for the response before the next fetch
    assert property (@(posedge clk) disable iff (rst) pending |-> !fetch_req_i);

endmodule : fetch_line_buffer

//--- source/data_line_buffer.sv
`timescale 1ns/100ps

module data_line_buffer
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        data_req_i,
    input  addr_t       data_addr_i,
    input  byte_mask_t  data_wmask_i,
    input  word_t       data_wdata_i,
    output logic        data_done_o,
    output word_t       data_rdata_o,
    line_port_if.client mem
);

    typedef enum logic [1:0] {S_IDLE, S_FILL, S_MERGE, S_WRITE} state_t;

    state_t     state;
    logic       line_valid;
    line_tag_t  line_tag;
    line_t      line_q;
    addr_t      addr_q;
    byte_mask_t wmask_q;
    word_t      wdata_q;
    logic       hit;
    logic       is_store;
    word_t      old_word;
    word_t      merged_word;

    assign hit      = line_valid && (data_addr_i[ADDR_W-1:OFFSET_W] == line_tag);
    assign is_store = |wmask_q;
    assign old_word = line_q[WORD_W*addr_q[OFFSET_W-1:2] +: WORD_W];

    // only enabled bytes change
    always_comb begin
        merged_word = old_word;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (wmask_q[b]) begin
                merged_word[8*b +: 8] = wdata_q[8*b +: 8];
            end
        end
    end

    // merge cycle keeps req low between refill and write-through
    assign mem.req   = (state == S_FILL) || (state == S_WRITE);
    assign mem.we    = (state == S_WRITE);
    assign mem.addr  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem.wline = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            line_valid  <= 1'b0;
            data_done_o <= 1'b0;
        end else begin
            data_done_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (data_req_i && !hit) begin
                        state <= S_FILL;
                    end else if (data_req_i && |data_wmask_i) begin
                        state <= S_MERGE;
                    end else if (data_req_i) begin
                        data_done_o <= 1'b1;
                    end
                end
                S_FILL: begin
                    if (mem.resp) begin
                        line_valid  <= 1'b1;
                        state       <= is_store ? S_MERGE : S_IDLE;
                        data_done_o <= !is_store;
                    end
                end
                S_MERGE: state <= S_WRITE;
                default: begin
                    if (mem.resp) begin
                        state       <= S_IDLE;
                        data_done_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && data_req_i) begin
            addr_q  <= data_addr_i;
            wmask_q <= data_wmask_i;
            wdata_q <= data_wdata_i;
            data_rdata_o <= line_q[WORD_W*data_addr_i[OFFSET_W-1:2] +: WORD_W];
        end
        if (state == S_FILL && mem.resp) begin
            line_q       <= mem.rline;
            line_tag     <= addr_q[ADDR_W-1:OFFSET_W];
            data_rdata_o <= mem.rline[WORD_W*addr_q[OFFSET_W-1:2] +: WORD_W];
        end
        if (state == S_MERGE) begin
            line_q[WORD_W*addr_q[OFFSET_W-1:2] +: WORD_W] <= merged_word;
            data_rdata_o <= merged_word;
        end
    end

    assert property (@(posedge clk) disable iff (rst) (state != S_IDLE) |-> !data_req_i);

endmodule : data_line_buffer

//--- source/line_arbiter.sv
`timescale 1ns/100ps

module line_arbiter (
    input  logic        clk,
    input  logic        rst,
    line_port_if.server inst_port,
    line_port_if.server data_port,
    line_port_if.client mem_port
);

    logic own_inst;
    logic own_data;

    // registered grant with the data side first
    always_ff @(posedge clk) begin
        if (rst) begin
            own_inst <= 1'b0;
            own_data <= 1'b0;
        end else if (mem_port.resp) begin
            own_inst <= 1'b0;
            own_data <= 1'b0;
        end else if (!own_inst && !own_data) begin
            if (data_port.req) begin
                own_data <= 1'b1;
            end else if (inst_port.req) begin
                own_inst <= 1'b1;
            end
        end
    end

    always_comb begin
        mem_port.req   = 1'b0;
        mem_port.we    = 1'b0;
        mem_port.addr  = '0;
        mem_port.wline = '0;
        if (own_data) begin
            mem_port.req   = data_port.req;
            mem_port.we    = data_port.we;
            mem_port.addr  = data_port.addr;
            mem_port.wline = data_port.wline;
        end else if (own_inst) begin
            mem_port.req   = inst_port.req;
            mem_port.we    = inst_port.we;
            mem_port.addr  = inst_port.addr;
            mem_port.wline = inst_port.wline;
        end
    end

    // response goes back to the owner only
    assign data_port.resp  = mem_port.resp && own_data;
    assign data_port.rline = own_data ? mem_port.rline : '0;
    assign inst_port.resp  = mem_port.resp && own_inst;
    assign inst_port.rline = own_inst ? mem_port.rline : '0;

    // a response only ends a granted transaction
    assert property (@(posedge clk) disable iff (rst) mem_port.resp |-> (own_inst || own_data));
    // the owner holds its request until the response
    assert property (@(posedge clk) disable iff (rst)
        (own_inst || own_data) |-> (own_data ? data_port.req : inst_port.req));

endmodule : line_arbiter

//--- source/burst_adapter.sv
`timescale 1ns/100ps

module burst_adapter
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    line_port_if.server line,
    output addr_t       bmem_addr_o,
    output logic        bmem_read_o,
    output logic        bmem_write_o,
    output beat_t       bmem_wdata_o,
    input  logic        bmem_ready_i,
    input  addr_t       bmem_raddr_i,
    input  beat_t       bmem_rdata_i,
    input  logic        bmem_rvalid_i
);

    typedef enum logic [2:0] {S_IDLE, S_RD_ISSUE, S_RD_WAIT, S_WR, S_RESP} state_t;

    state_t state;
    logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
    line_t  line_q;
    addr_t  addr_q;

    assign bmem_addr_o  = addr_q;
    // strobe only lands in a ready cycle
    assign bmem_read_o  = (state == S_RD_ISSUE) && bmem_ready_i;
    assign bmem_write_o = (state == S_WR);
    assign bmem_wdata_o = line_q[BEAT_W-1:0];

    assign line.resp  = (state == S_RESP);
    assign line.rline = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    beat_cnt <= '0;
                    if (line.req) begin
                        state <= line.we ? S_WR : S_RD_ISSUE;
                    end
                end
                S_RD_ISSUE: begin
                    if (bmem_ready_i) begin
                        state <= S_RD_WAIT;
                    end
                end
                S_RD_WAIT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        // counter wraps after the last beat
                        if (&beat_cnt) begin
                            state <= S_RESP;
                        end
                    end
                end
                S_WR: begin
                    if (bmem_ready_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (&beat_cnt) begin
                            state <= S_RESP;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // line register doubles as read collector and write shifter
    always_ff @(posedge clk) begin
        if (state == S_IDLE && line.req) begin
            addr_q <= line.addr;
            line_q <= line.wline;
        end else if (state == S_RD_WAIT && bmem_rvalid_i) begin
            line_q[beat_cnt*BEAT_W +: BEAT_W] <= bmem_rdata_i;
        end else if (state == S_WR && bmem_ready_i) begin
            line_q <= line_q >> BEAT_W;
        end
    end

    // the client keeps its request and address until the response
    assert property (@(posedge clk) disable iff (rst)
        (state != S_IDLE) |-> line.req && (line.addr == addr_q));
    assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> (state == S_RD_WAIT) && (bmem_raddr_i == addr_q));

endmodule : burst_adapter

//--- source/mem_frontend.sv
`timescale 1ns/100ps

module mem_frontend
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_req_i,
    input  addr_t      fetch_addr_i,
    output logic       fetch_valid_o,
    output word_t      fetch_inst_o,
    input  logic       data_req_i,
    input  addr_t      data_addr_i,
    input  byte_mask_t data_wmask_i,
    input  word_t      data_wdata_i,
    output logic       data_done_o,
    output word_t      data_rdata_o,
    output addr_t      bmem_addr_o,
    output logic       bmem_read_o,
    output logic       bmem_write_o,
    output beat_t      bmem_wdata_o,
    input  logic       bmem_ready_i,
    input  addr_t      bmem_raddr_i,
    input  beat_t      bmem_rdata_i,
    input  logic       bmem_rvalid_i
);

    line_port_if inst_lp ();
    line_port_if data_lp ();
    line_port_if mem_lp ();

    fetch_line_buffer u_fetch (
        .clk           (clk),
        .rst           (rst),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_inst_o  (fetch_inst_o),
        .mem           (inst_lp.client)
    );

    data_line_buffer u_data (
        .clk          (clk),
        .rst          (rst),
        .data_req_i   (data_req_i),
        .data_addr_i  (data_addr_i),
        .data_wmask_i (data_wmask_i),
        .data_wdata_i (data_wdata_i),
        .data_done_o  (data_done_o),
        .data_rdata_o (data_rdata_o),
        .mem          (data_lp.client)
    );

    line_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .inst_port (inst_lp.server),
        .data_port (data_lp.server),
        .mem_port  (mem_lp.client)
    );

    burst_adapter u_burst (
        .clk           (clk),
        .rst           (rst),
        .line          (mem_lp.server),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

endmodule : mem_frontend

//--- test/burst_mem_model.sv
`timescale 1ns/100ps

module burst_mem_model
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  addr_t bmem_addr_i,
    input  logic  bmem_read_i,
    input  logic  bmem_write_i,
    input  beat_t bmem_wdata_i,
    output logic  bmem_ready_o,
    output addr_t bmem_raddr_o,
    output beat_t bmem_rdata_o,
    output logic  bmem_rvalid_o
);

    localparam int MEM_WORDS = 16384;

    word_t       mem_words [0:MEM_WORDS-1];
    logic [31:0] rng;
    addr_t       rd_addr;
    int          rd_left;
    int          rd_idx;
    int          wr_idx;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t word_at(input addr_t a);
        return mem_words[a[15:2]];
    endfunction

    // upper half is the address, lower half its complement
    initial begin
        addr_t a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = i * 4;
            mem_words[i] = {a[15:0], ~a[15:0]};
        end
        rng           = 32'h339430bb;
        rd_addr       = '0;
        rd_left       = 0;
        rd_idx        = 0;
        wr_idx        = 0;
        bmem_ready_o  = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_left = 0;
            rd_idx  = 0;
            wr_idx  = 0;
        end else begin
            // beat on the bus at this edge was taken
            if (bmem_rvalid_o) begin
                rd_idx  = rd_idx + 1;
                rd_left = rd_left - 1;
            end
            if (bmem_read_i) begin
                rd_addr = bmem_addr_i;
                rd_left = BEATS_PER_LINE;
                rd_idx  = 0;
            end
            if (bmem_write_i && bmem_ready_o) begin
                mem_words[(bmem_addr_i + 8 * wr_idx) >> 2]     = bmem_wdata_i[31:0];
                mem_words[(bmem_addr_i + 8 * wr_idx + 4) >> 2] = bmem_wdata_i[63:32];
                wr_idx = (wr_idx + 1) % BEATS_PER_LINE;
            end
        end
        #10;
        rng = xorshift(rng);
        // roughly one stall cycle in four
        bmem_ready_o = (rng[1:0] != 2'b00);
        bmem_raddr_o = rd_addr;
        if (!rst && rd_left > 0 && rng[3:2] != 2'b00) begin
            bmem_rvalid_o = 1'b1;
            bmem_rdata_o  = {word_at(rd_addr + 8 * rd_idx + 4), word_at(rd_addr + 8 * rd_idx)};
        end else begin
            bmem_rvalid_o = 1'b0;
        end
    end

endmodule : burst_mem_model

//--- test/tb_mem_frontend.sv
`timescale 1ns/100ps

module tb_mem_frontend
    import mem_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int STALL_LIMIT = 300;

    logic       clk;
    logic       rst;
    logic       fetch_req_i;
    addr_t      fetch_addr_i;
    logic       fetch_valid_o;
    word_t      fetch_inst_o;
    logic       data_req_i;
    addr_t      data_addr_i;
    byte_mask_t data_wmask_i;
    word_t      data_wdata_i;
    logic       data_done_o;
    word_t      data_rdata_o;
    addr_t      bmem_addr;
    logic       bmem_read;
    logic       bmem_write;
    beat_t      bmem_wdata;
    logic       bmem_ready;
    addr_t      bmem_raddr;
    beat_t      bmem_rdata;
    logic       bmem_rvalid;

    logic [7:0] kinds [$];
    addr_t      addr_a [$];
    addr_t      addr_b [$];
    byte_mask_t masks [$];
    word_t      wdatas [$];
    word_t      exp_a [$];
    word_t      exp_b [$];
    int         n_entries;
    logic       loaded;
    int         mismatches;
    int         failures;

    // lines the buffers should hold after each access
    line_tag_t  fetch_tag;
    logic       fetch_tag_valid;
    line_tag_t  data_tag;
    logic       data_tag_valid;
    addr_t      store_addr_q [$];
    word_t      store_word_q [$];

    mem_frontend u_dut (
        .clk           (clk),
        .rst           (rst),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_inst_o  (fetch_inst_o),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_wmask_i  (data_wmask_i),
        .data_wdata_i  (data_wdata_i),
        .data_done_o   (data_done_o),
        .data_rdata_o  (data_rdata_o),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_write_o  (bmem_write),
        .bmem_wdata_o  (bmem_wdata),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    burst_mem_model u_mem (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_write_i  (bmem_write),
        .bmem_wdata_i  (bmem_wdata),
        .bmem_ready_o  (bmem_ready),
        .bmem_raddr_o  (bmem_raddr),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // last stored value of a memory word, else the initial rule
    function automatic word_t expected_mem_word(input addr_t a);
        word_t w;
        addr_t wa;
        wa = {a[ADDR_W-1:2], 2'b00};
        w  = {wa[15:0], ~wa[15:0]};
        foreach (store_addr_q[i]) begin
            if (store_addr_q[i] == wa) begin
                w = store_word_q[i];
            end
        end
        return w;
    endfunction

    task automatic check_idle(input string name);
        logic [3:0] outs;
        outs = {fetch_valid_o, data_done_o, bmem_read, bmem_write};
        if (outs !== 4'b0000) begin
            mismatches++;
            $display("MISMATCH %s: expected %b actual %b", name, 4'b0000, outs);
        end
    endtask

    task automatic run_fetch(input int idx, input addr_t addr, input word_t expected);
        string name;
        logic  was_hit;
        int    cycles;
        name    = $sformatf("entry %0d fetch", idx);
        was_hit = fetch_tag_valid && (addr[ADDR_W-1:OFFSET_W] == fetch_tag);
        fetch_req_i  = 1'b1;
        fetch_addr_i = addr;
        @(posedge clk);
        #10;
        fetch_req_i = 1'b0;
        cycles = 1;
        while (!fetch_valid_o && cycles < STALL_LIMIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!fetch_valid_o) begin
            failures++;
            $display("%s: no fetch response within %0d cycles", name, STALL_LIMIT);
        end else begin
            if (fetch_inst_o !== expected) begin
                mismatches++;
                $display("MISMATCH %s: expected %h actual %h", name, expected, fetch_inst_o);
            end
            if (was_hit && cycles != 1) begin
                mismatches++;
                $display("MISMATCH %s hit latency: expected %0d actual %0d", name, 1, cycles);
            end
        end
        fetch_tag       = addr[ADDR_W-1:OFFSET_W];
        fetch_tag_valid = 1'b1;
    endtask

    task automatic run_data(input int idx, input addr_t addr, input byte_mask_t mask,
                            input word_t wdata, input word_t expected);
        string name;
        logic  was_hit;
        int    cycles;
        name    = $sformatf("entry %0d %s", idx, (mask == '0) ? "load" : "store");
        was_hit = data_tag_valid && (addr[ADDR_W-1:OFFSET_W] == data_tag);
        data_req_i   = 1'b1;
        data_addr_i  = addr;
        data_wmask_i = mask;
        data_wdata_i = wdata;
        @(posedge clk);
        #10;
        data_req_i   = 1'b0;
        data_wmask_i = '0;
        cycles = 1;
        while (!data_done_o && cycles < STALL_LIMIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!data_done_o) begin
            failures++;
            $display("%s: no data response within %0d cycles", name, STALL_LIMIT);
        end else begin
            if (data_rdata_o !== expected) begin
                mismatches++;
                $display("MISMATCH %s: expected %h actual %h", name, expected, data_rdata_o);
            end
            // only load hits answer in one cycle since a store still writes through
            if (was_hit && mask == '0 && cycles != 1) begin
                mismatches++;
                $display("MISMATCH %s hit latency: expected %0d actual %0d", name, 1, cycles);
            end
        end
        data_tag       = addr[ADDR_W-1:OFFSET_W];
        data_tag_valid = 1'b1;
    endtask

    // whole line in memory after a write-through
    task automatic check_line(input int idx, input addr_t addr);
        addr_t a;
        word_t expected;
        word_t actual;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            a        = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} + 4 * k;
            expected = expected_mem_word(a);
            actual   = u_mem.word_at(a);
            if (actual !== expected) begin
                mismatches++;
                $display("MISMATCH entry %0d memory word %h: expected %h actual %h",
                         idx, a, expected, actual);
            end
        end
    endtask

    task automatic load_stimulus();
        int         fd;
        int         n;
        string      line;
        logic [7:0] kind;
        addr_t      a1;
        addr_t      a2;
        byte_mask_t m;
        word_t      wd;
        word_t      e1;
        word_t      e2;
        fd = $fopen("test/frontend_stim.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("cannot open stimulus file test/frontend_stim.txt");
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h %h", kind, a1, a2, m, wd, e1, e2);
            if (n != 7) begin
                failures++;
                $display("malformed stimulus line: %s", line);
            end else begin
                kinds.push_back(kind);
                addr_a.push_back(a1);
                addr_b.push_back(a2);
                masks.push_back(m);
                wdatas.push_back(wd);
                exp_a.push_back(e1);
                exp_b.push_back(e2);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        loaded          = 1'b0;
        n_entries       = 0;
        mismatches      = 0;
        failures        = 0;
        fetch_tag_valid = 1'b0;
        data_tag_valid  = 1'b0;
        fetch_tag       = '0;
        data_tag        = '0;
        rst             = 1'b1;
        fetch_req_i     = 1'b0;
        fetch_addr_i    = '0;
        data_req_i      = 1'b0;
        data_addr_i     = '0;
        data_wmask_i    = '0;
        data_wdata_i    = '0;

        load_stimulus();
        n_entries = kinds.size();
        loaded    = 1'b1;
        if (n_entries == 0) begin
            failures++;
            $display("no stimulus entries were loaded");
        end

        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            #10;
            check_idle("reset");
        end
        rst = 1'b0;
        @(posedge clk);
        #10;
        check_idle("after reset");

        for (int i = 0; i < n_entries; i++) begin
            case (kinds[i])
                "F": run_fetch(i, addr_a[i], exp_a[i]);
                "L": run_data(i, addr_a[i], '0, '0, exp_a[i]);
                "S": begin
                    run_data(i, addr_a[i], masks[i], wdatas[i], exp_a[i]);
                    store_addr_q.push_back({addr_a[i][ADDR_W-1:2], 2'b00});
                    store_word_q.push_back(exp_a[i]);
                    check_line(i, addr_a[i]);
                end
                "P": begin
                    fork
                        run_fetch(i, addr_a[i], exp_a[i]);
                        run_data(i, addr_b[i], '0, '0, exp_b[i]);
                    join
                end
                default: begin
                    failures++;
                    $display("entry %0d has an unknown kind %c", i, kinds[i]);
                end
            endcase
        end

        $display("mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // one stall limit per entry plus reset bounds the whole run
    initial begin
        wait (loaded);
        #((n_entries * STALL_LIMIT + 10) * CLK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("mismatches: %0d, other failures: %0d", mismatches, failures + 1);
        $display("Some tests failed");
        $finish;
    end

endmodule : tb_mem_frontend

//--- test/frontend_stim.txt
# kind addr addr2 mask wdata expect expect2, all hex except kind
# kind F fetch, L load, S store, P fetch at addr and load at addr2 in one cycle
# expect is the fetch word, the load word or the merged store word
# expect2 is the load word of a P entry, unused columns are 0
F 00001000 00000000 0 00000000 1000efff 00000000
F 00001004 00000000 0 00000000 1004effb 00000000
F 0000101c 00000000 0 00000000 101cefe3 00000000
L 00002000 00000000 0 00000000 2000dfff 00000000
L 00002008 00000000 0 00000000 2008dff7 00000000
L 00002014 00000000 0 00000000 2014dfeb 00000000
L 00002040 00000000 0 00000000 2040dfbf 00000000
L 00002004 00000000 0 00000000 2004dffb 00000000
S 00002008 00000000 3 aabbccdd 2008ccdd 00000000
L 00002008 00000000 0 00000000 2008ccdd 00000000
S 00002064 00000000 c 11223344 1122df9b 00000000
L 00002064 00000000 0 00000000 1122df9b 00000000
S 00002060 00000000 5 a5a5a5a5 20a5dfa5 00000000
L 00002064 00000000 0 00000000 1122df9b 00000000
P 00001100 00002100 0 00000000 1100eeff 2100deff
P 00001204 00002208 0 00000000 1204edfb 2208ddf7
F 00001108 00000000 0 00000000 1108eef7 00000000
L 00002060 00000000 0 00000000 20a5dfa5 00000000
S 00002300 00000000 f deadbeef deadbeef 00000000
P 00001304 00002300 0 00000000 1304ecfb deadbeef

//--- list.f
source/mem_pkg.sv
source/line_port_if.sv
source/fetch_line_buffer.sv
source/data_line_buffer.sv
source/line_arbiter.sv
source/burst_adapter.sv
source/mem_frontend.sv
test/burst_mem_model.sv
test/tb_mem_frontend.sv
